/* i2c_master_pkg.sv */
`default_nettype none

package i2c_master_pkg;

    typedef logic [7:0]  reg_byte_t;    // register value or bus byte
    typedef logic [4:0]  reg_addr_t;    // bits 4:2 pick the register
    typedef logic [15:0] prescale_t;

    typedef enum logic [2:0] {
        ADDR_ADR   = 3'd0,
        ADDR_FDR   = 3'd1,
        ADDR_CR    = 3'd2,
        ADDR_SR    = 3'd3,
        ADDR_DR    = 3'd4,
        ADDR_DFSRR = 3'd5
    } reg_sel_e;

    localparam int CR_MEN  = 7;
    localparam int CR_MIEN = 6;
    localparam int CR_MSTA = 5;
    localparam int CR_MTX  = 4;
    localparam int CR_TXAK = 3;
    localparam int CR_RSTA = 2;

    localparam int SR_MCF   = 7;
    localparam int SR_MAAS  = 6;
    localparam int SR_MBB   = 5;
    localparam int SR_MAL   = 4;
    localparam int SR_BCSTM = 3;
    localparam int SR_SRW   = 2;
    localparam int SR_MIF   = 1;
    localparam int SR_RXAK  = 0;

    localparam reg_byte_t SR_RESET       = 8'h81;
    localparam reg_byte_t DFSRR_RESET    = 8'h10;
    localparam prescale_t PRESCALE_RESET = 16'd384;
    localparam prescale_t FILTER_RESET   = 16'd24;    // 384 / 16

    // both enums share one encoding so a state maps straight to its command
    typedef enum logic [2:0] {
        CMD_IDLE, CMD_START, CMD_STOP, CMD_WRITE,
        CMD_READ, CMD_WR_ACK, CMD_RD_ACK, CMD_RESTART
    } byte_cmd_e;

    typedef enum logic [2:0] {
        SM_IDLE, SM_START, SM_STOP, SM_WRITE,
        SM_READ, SM_WR_ACK, SM_RD_ACK, SM_RESTART
    } seq_state_e;

    typedef struct packed {
        logic start;
        logic stop;
        logic write;
        logic read;
        logic restart;
    } seq_event_t;

    typedef struct packed {
        logic      set_busy;
        logic      clr_busy;
        logic      set_mcf;
        logic      set_mif;
        logic      upd_flags;    // load rxack and al
        logic      rxack;
        logic      al;
        logic      rx_valid;
        reg_byte_t rx_data;
    } status_upd_t;

    typedef struct packed {
        byte_cmd_e cmd;
        reg_byte_t tx_data;
    } byte_req_t;

    typedef struct packed {
        logic      done;
        logic      rxack;
        logic      al;
        reg_byte_t rx_data;
    } byte_rsp_t;

endpackage

`default_nettype wire

/* i2c_restoring_divider.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_restoring_divider #(
    parameter int WIDTH = 16
) (
    input  wire              sysclk_i,
    input  wire              reset_n_i,
    input  wire              start_i,
    input  wire [WIDTH-1:0]  dividend_i,
    input  wire [WIDTH-1:0]  divisor_i,
    output logic             ready_o,
    output logic [WIDTH-1:0] quotient_o,
    output logic             done_o
);

    localparam int CNT_W = $clog2(WIDTH);

    typedef enum logic [1:0] {IDLE, SUB, SHIFT, DONE} div_state_e;

    div_state_e       state_q;
    logic [CNT_W-1:0] bit_cnt_q;
    logic [WIDTH:0]   rem_q;     // spare msb holds the shifted partial remainder
    logic [WIDTH-1:0] quo_q;     // dividend bits shift out, quotient bits shift in
    logic [WIDTH-1:0] dsr_q;

    always_ff @(posedge sysclk_i or negedge reset_n_i)
    begin
        if (!reset_n_i)
        begin
            state_q   <= IDLE;
            bit_cnt_q <= '0;
        end
        else
        begin
            case (state_q)
                IDLE:
                begin
                    bit_cnt_q <= '0;
                    if (start_i)
                        state_q <= SHIFT;
                end
                SHIFT:
                    state_q <= SUB;
                SUB:
                begin
                    bit_cnt_q <= bit_cnt_q + 1'b1;
                    state_q   <= (bit_cnt_q == CNT_W'(WIDTH - 1)) ? DONE : SHIFT;
                end
                default:
                    state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge sysclk_i)
    begin
        case (state_q)
            IDLE:
            begin
                rem_q <= '0;
                quo_q <= dividend_i;
                dsr_q <= divisor_i;
            end
            SHIFT:
            begin
                rem_q <= {rem_q[WIDTH-1:0], quo_q[WIDTH-1]};
                quo_q <= {quo_q[WIDTH-2:0], 1'b0};
            end
            SUB:
            begin
                if (rem_q >= {1'b0, dsr_q})    // zero divisor always passes
                begin
                    rem_q    <= rem_q - {1'b0, dsr_q};
                    quo_q[0] <= 1'b1;
                end
            end
            default: ;
        endcase
    end

    assign ready_o    = (state_q == IDLE);
    assign done_o     = (state_q == DONE);
    assign quotient_o = quo_q;

endmodule

`default_nettype wire

/* i2c_clock_config.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_clock_config
    import i2c_master_pkg::*;
#(
    parameter int PRESCALE_W = 16
) (
    input  wire                   sysclk_i,
    input  wire                   reset_n_i,
    input  wire reg_byte_t        fdr_i,
    input  wire reg_byte_t        dfsrr_i,
    output logic [PRESCALE_W-1:0] prescale_o,
    output logic [PRESCALE_W-1:0] filter_rate_o
);

    // scl divider per fdr[5:0]
    localparam prescale_t FDR_TABLE [64] = '{
        384,   416,   480,   576,   640,   704,   832,   1024,
        1152,  1280,  1536,  1920,  2304,  2560,  3072,  3840,
        4608,  5120,  6144,  7680,  9216,  10240, 12288, 15360,
        18432, 20480, 24576, 30720, 36864, 40960, 49152, 61440,
        256,   288,   320,   352,   384,   448,   512,   576,
        640,   768,   896,   1024,  1280,  1536,  1792,  2048,
        2560,  3072,  3584,  4096,  5120,  6144,  7168,  8192,
        10240, 12288, 14336, 16384, 20480, 24576, 28672, 32768
    };

    logic                  div_ready;
    logic                  div_done;
    logic [PRESCALE_W-1:0] div_quotient;

    always_ff @(posedge sysclk_i or negedge reset_n_i)
    begin
        if (!reset_n_i)
        begin
            prescale_o    <= PRESCALE_W'(PRESCALE_RESET);
            filter_rate_o <= PRESCALE_W'(FILTER_RESET);
        end
        else
        begin
            prescale_o <= PRESCALE_W'(FDR_TABLE[fdr_i[5:0]]);   // bits 7:6 ignored
            if (div_done)
                filter_rate_o <= div_quotient;
        end
    end

    i2c_restoring_divider #(
        .WIDTH      (PRESCALE_W)
    ) u_filter_div (
        .sysclk_i   (sysclk_i),
        .reset_n_i  (reset_n_i),
        .start_i    (div_ready),    // free running, new division on every idle cycle
        .dividend_i (prescale_o),
        .divisor_i  (PRESCALE_W'(dfsrr_i[5:0])),
        .ready_o    (div_ready),
        .quotient_o (div_quotient),
        .done_o     (div_done)
    );

endmodule

`default_nettype wire

/* i2c_reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_reg_file
    import i2c_master_pkg::*;
(
    input  wire              sysclk_i,
    input  wire              reset_n_i,
    input  wire              wr_ena_i,
    input  wire reg_addr_t   wr_addr_i,
    input  wire reg_byte_t   wr_data_i,
    input  wire              rd_ena_i,
    input  wire reg_addr_t   rd_addr_i,
    input  wire status_upd_t status_upd_i,
    output reg_byte_t        rd_data_o,
    output logic             data_ready_o,
    output seq_event_t       event_o,
    output reg_byte_t        cr_o,
    output reg_byte_t        dr_o,
    output reg_byte_t        fdr_o,
    output reg_byte_t        dfsrr_o
);

    reg_byte_t adr_q;
    reg_byte_t sr_q;
    reg_sel_e  wr_sel;
    reg_sel_e  rd_sel;
    logic      xfer_open;    // bus held and last byte phase complete
    logic      cr_wr_q;

    assign wr_sel       = reg_sel_e'(wr_addr_i[4:2]);
    assign rd_sel       = reg_sel_e'(rd_addr_i[4:2]);
    assign xfer_open    = sr_q[SR_MBB] & sr_q[SR_MCF];
    assign data_ready_o = sr_q[SR_MCF];

    always_ff @(posedge sysclk_i or negedge reset_n_i)
    begin
        if (!reset_n_i)
        begin
            adr_q     <= '0;
            fdr_o     <= '0;
            cr_o      <= '0;
            sr_q      <= SR_RESET;
            dr_o      <= '0;
            dfsrr_o   <= DFSRR_RESET;
            rd_data_o <= 8'hff;
            event_o   <= '0;
            cr_wr_q   <= 1'b0;
        end
        else
        begin
            event_o         <= '0;
            event_o.restart <= cr_wr_q & cr_o[CR_RSTA];    // taken from the loaded CR
            cr_wr_q         <= 1'b0;
            if (wr_ena_i)
            begin
                case (wr_sel)
                    ADDR_ADR:   adr_q   <= wr_data_i;
                    ADDR_FDR:   fdr_o   <= wr_data_i;
                    ADDR_DFSRR: dfsrr_o <= wr_data_i;
                    ADDR_CR:
                    begin
                        cr_o          <= wr_data_i;
                        cr_wr_q       <= 1'b1;
                        event_o.start <= ~cr_o[CR_MSTA] & wr_data_i[CR_MSTA];
                        event_o.stop  <= cr_o[CR_MSTA] & ~wr_data_i[CR_MSTA];
                    end
                    ADDR_SR:
                    begin
                        if (xfer_open)
                        begin
                            sr_q[SR_MAL] <= wr_data_i[SR_MAL];
                            sr_q[SR_MIF] <= wr_data_i[SR_MIF];
                        end
                    end
                    ADDR_DR:
                    begin
                        if (xfer_open & ~sr_q[SR_MIF])
                        begin
                            sr_q[SR_MCF]  <= 1'b0;
                            dr_o          <= wr_data_i;
                            event_o.write <= 1'b1;
                        end
                    end
                    default: ;
                endcase
            end
            if (rd_ena_i)
            begin
                case (rd_sel)
                    ADDR_ADR:   rd_data_o <= adr_q;
                    ADDR_FDR:   rd_data_o <= fdr_o;
                    ADDR_CR:    rd_data_o <= cr_o;
                    ADDR_DFSRR: rd_data_o <= dfsrr_o;
                    ADDR_DR:
                    begin
                        if (xfer_open)    // data comes back later via rx_valid
                        begin
                            sr_q[SR_MCF] <= 1'b0;
                            event_o.read <= 1'b1;
                        end
                    end
                    default:    rd_data_o <= sr_q;    // SR and unused slots
                endcase
            end
            // sequencer updates win over host writes in the same cycle
            if (status_upd_i.set_busy)
                sr_q[SR_MBB] <= 1'b1;
            if (status_upd_i.clr_busy)
                sr_q[SR_MBB] <= 1'b0;
            if (status_upd_i.set_mcf)
                sr_q[SR_MCF] <= 1'b1;
            if (status_upd_i.set_mif)
                sr_q[SR_MIF] <= 1'b1;
            if (status_upd_i.upd_flags)
            begin
                sr_q[SR_RXAK] <= status_upd_i.rxack;
                sr_q[SR_MAL]  <= status_upd_i.al;
            end
            if (status_upd_i.rx_valid)
                rd_data_o <= status_upd_i.rx_data;
        end
    end

endmodule

`default_nettype wire

/* i2c_cmd_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_cmd_sequencer
    import i2c_master_pkg::*;
(
    input  wire             sysclk_i,
    input  wire             reset_n_i,
    input  wire seq_event_t event_i,
    input  wire reg_byte_t  cr_i,
    input  wire reg_byte_t  dr_i,
    input  wire byte_rsp_t  byte_rsp_i,
    output byte_req_t       byte_req_o,
    output logic            byte_go_o,
    output status_upd_t     status_upd_o
);

    seq_state_e state_q;
    seq_state_e issue_op;
    logic       issue;
    logic       pending_q;    // command out, done not seen yet
    logic       go_q;         // cmd is stable one cycle ahead of go
    logic       men;
    logic       bus_own;
    logic       tx_mode;
    logic       rsp_done;

    assign men      = cr_i[CR_MEN];
    assign bus_own  = men & cr_i[CR_MSTA];
    assign tx_mode  = bus_own & cr_i[CR_MTX];
    assign rsp_done = pending_q & byte_rsp_i.done;

    always_comb
    begin
        issue    = 1'b1;
        issue_op = state_q;
        if (rsp_done & bus_own & (state_q == SM_WRITE))
            issue_op = SM_RD_ACK;
        else if (rsp_done & bus_own & (state_q == SM_READ) & ~cr_i[CR_TXAK])
            issue_op = SM_WR_ACK;
        else if (pending_q)
            issue = 1'b0;
        else if (event_i.stop & men)
            issue_op = SM_STOP;
        else if (event_i.restart & tx_mode & cr_i[CR_RSTA] &
                 (state_q inside {SM_WR_ACK, SM_RD_ACK}))
            issue_op = SM_RESTART;
        else if (event_i.start & tx_mode & (state_q == SM_IDLE))
            issue_op = SM_START;
        else if (event_i.write & (state_q inside {SM_START, SM_RD_ACK, SM_RESTART}))
            issue_op = SM_WRITE;
        else if (event_i.read & bus_own)
            issue_op = SM_READ;
        else
            issue = 1'b0;
    end

    always_ff @(posedge sysclk_i or negedge reset_n_i)
    begin
        if (!reset_n_i)
        begin
            state_q      <= SM_IDLE;
            byte_req_o   <= '{cmd: CMD_IDLE, tx_data: '0};
            pending_q    <= 1'b0;
            go_q         <= 1'b0;
            byte_go_o    <= 1'b0;
            status_upd_o <= '0;
        end
        else
        begin
            go_q         <= issue;
            byte_go_o    <= go_q;
            status_upd_o <= '0;
            if (rsp_done)
                pending_q <= 1'b0;
            if (issue)
            begin
                state_q            <= issue_op;
                byte_req_o.cmd     <= byte_cmd_e'(issue_op);
                byte_req_o.tx_data <= dr_i;
                pending_q          <= 1'b1;
            end
            else if (rsp_done & men & (state_q == SM_STOP))
            begin
                state_q        <= SM_IDLE;
                byte_req_o.cmd <= CMD_IDLE;
            end
            if (rsp_done)
            begin
                case (state_q)
                    SM_START:
                        status_upd_o.set_busy <= bus_own;
                    SM_STOP:
                    begin
                        status_upd_o.clr_busy <= men;
                        status_upd_o.set_mcf  <= men;
                    end
                    SM_READ:
                    begin
                        status_upd_o.rx_valid <= bus_own;
                        status_upd_o.rx_data  <= byte_rsp_i.rx_data;
                        status_upd_o.set_mcf  <= bus_own & cr_i[CR_TXAK];    // no ack phase
                    end
                    SM_WR_ACK, SM_RD_ACK:
                    begin
                        status_upd_o.set_mcf   <= bus_own;
                        status_upd_o.set_mif   <= bus_own;
                        status_upd_o.upd_flags <= bus_own;
                        status_upd_o.rxack     <= byte_rsp_i.rxack;
                        status_upd_o.al        <= byte_rsp_i.al;
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* i2c_master_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_master_ctrl
    import i2c_master_pkg::*;
#(
    parameter int PRESCALE_W = 16
) (
    input  wire            sysclk_i,
    input  wire            reset_n_i,
    input  wire            wr_ena_i,
    input  wire reg_addr_t wr_addr_i,
    input  wire reg_byte_t wr_data_i,
    input  wire            rd_ena_i,
    input  wire reg_addr_t rd_addr_i,
    input  wire byte_rsp_t byte_rsp_i,
    output reg_byte_t      rd_data_o,
    output logic           data_ready_o,
    output logic           core_enable_o,
    output prescale_t      prescale_o,
    output prescale_t      filter_rate_o,
    output byte_req_t      byte_req_o,
    output logic           byte_go_o
);

    seq_event_t  seq_event;
    status_upd_t status_upd;
    reg_byte_t   cr;
    reg_byte_t   dr;
    reg_byte_t   fdr;
    reg_byte_t   dfsrr;

    assign core_enable_o = cr[CR_MEN];    // enable to the byte controller

    i2c_reg_file u_reg_file (
        .sysclk_i,
        .reset_n_i,
        .wr_ena_i,
        .wr_addr_i,
        .wr_data_i,
        .rd_ena_i,
        .rd_addr_i,
        .status_upd_i (status_upd),
        .rd_data_o,
        .data_ready_o,
        .event_o      (seq_event),
        .cr_o         (cr),
        .dr_o         (dr),
        .fdr_o        (fdr),
        .dfsrr_o      (dfsrr)
    );

    i2c_cmd_sequencer u_cmd_seq (
        .sysclk_i,
        .reset_n_i,
        .event_i      (seq_event),
        .cr_i         (cr),
        .dr_i         (dr),
        .byte_rsp_i,
        .byte_req_o,
        .byte_go_o,
        .status_upd_o (status_upd)
    );

    i2c_clock_config #(
        .PRESCALE_W   (PRESCALE_W)
    ) u_clock_config (
        .sysclk_i,
        .reset_n_i,
        .fdr_i        (fdr),
        .dfsrr_i      (dfsrr),
        .prescale_o,
        .filter_rate_o
    );

endmodule

`default_nettype wire

/* i2c_master_ctrl_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_master_ctrl_sva
    import i2c_master_pkg::*;
(
    input wire            sysclk_i,
    input wire            reset_n_i,
    input wire            byte_go_i,
    input wire byte_req_t byte_req_i
);

    int unsigned fail_cnt = 0;    // failed properties so far

    go_single_cycle: assert property (@(posedge sysclk_i) disable iff (!reset_n_i)
        byte_go_i |=> !byte_go_i)
    else
    begin
        $error("byte_go_o high for two cycles in a row");
        fail_cnt++;
    end

    go_has_cmd: assert property (@(posedge sysclk_i) disable iff (!reset_n_i)
        byte_go_i |-> (byte_req_i.cmd != CMD_IDLE))
    else
    begin
        $error("byte_go_o with CMD_IDLE on byte_req_o");
        fail_cnt++;
    end

    go_low_in_reset: assert property (@(posedge sysclk_i) !reset_n_i |-> !byte_go_i)
    else
    begin
        $error("byte_go_o high during reset");
        fail_cnt++;
    end

endmodule

bind i2c_master_ctrl i2c_master_ctrl_sva u_sva (
    .sysclk_i   (sysclk_i),
    .reset_n_i  (reset_n_i),
    .byte_go_i  (byte_go_o),
    .byte_req_i (byte_req_o)
);

`default_nettype wire

/* tb_i2c_master_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_i2c_master_ctrl
    import i2c_master_pkg::*;
();

    localparam logic [5:0] FDR_CODES [6] = '{6'h00, 6'h07, 6'h1f, 6'h20, 6'h2f, 6'h3f};

    logic        sysclk;
    logic        reset_n;
    logic        wr_ena;
    reg_addr_t   wr_addr;
    reg_byte_t   wr_data;
    logic        rd_ena;
    reg_addr_t   rd_addr;
    byte_rsp_t   byte_rsp = '0;
    reg_byte_t   rd_data;
    logic        data_ready;
    logic        core_enable;
    prescale_t   prescale;
    prescale_t   filter_rate;
    byte_req_t   byte_req;
    logic        byte_go;

    int unsigned go_cnt = 0;     // commands seen by the byte controller model
    int unsigned done_cnt = 0;
    reg_byte_t   last_rx = '0;
    logic        last_rxack = 1'b0;

    i2c_master_ctrl #(
        .PRESCALE_W    (16)
    ) dut_i (
        .sysclk_i      (sysclk),
        .reset_n_i     (reset_n),
        .wr_ena_i      (wr_ena),
        .wr_addr_i     (wr_addr),
        .wr_data_i     (wr_data),
        .rd_ena_i      (rd_ena),
        .rd_addr_i     (rd_addr),
        .byte_rsp_i    (byte_rsp),
        .rd_data_o     (rd_data),
        .data_ready_o  (data_ready),
        .core_enable_o (core_enable),
        .prescale_o    (prescale),
        .filter_rate_o (filter_rate),
        .byte_req_o    (byte_req),
        .byte_go_o     (byte_go)
    );

    always #4 sysclk = ~sysclk;

    // byte controller model, answers every go with one done pulse
    always @(negedge sysclk)
    begin
        int unsigned delay;
        if (reset_n && byte_go)
        begin
            go_cnt <= go_cnt + 1;
            delay = $urandom_range(10, 3);
            repeat (delay - 1) @(negedge sysclk);
            byte_rsp.rx_data = 8'($urandom);
            byte_rsp.rxack   = 1'($urandom);
            byte_rsp.done    = 1'b1;
            last_rx    <= byte_rsp.rx_data;
            last_rxack <= byte_rsp.rxack;
            done_cnt   <= done_cnt + 1;
            @(negedge sysclk);
            byte_rsp.done = 1'b0;
        end
    end

    function automatic prescale_t prescale_ref(input reg_byte_t fdr);
        case (fdr[5:0])
            6'h00:   return 16'd384;
            6'h07:   return 16'd1024;
            6'h1f:   return 16'd61440;
            6'h20:   return 16'd256;
            6'h2f:   return 16'd2048;
            6'h3f:   return 16'd32768;
            default: return 16'd0;
        endcase
    endfunction

    function automatic prescale_t filter_ref(input prescale_t scale, input reg_byte_t dfsrr);
        if (dfsrr[5:0] == 6'd0)
            return 16'hffff;
        return scale / prescale_t'(dfsrr[5:0]);
    endfunction

    function automatic reg_byte_t sr_ref(input logic mcf, input logic mbb, input logic mal,
                                         input logic mif, input logic rxack);
        reg_byte_t sr;
        sr = '0;    // MAAS, BCSTM and SRW stay zero
        sr[SR_MCF]  = mcf;
        sr[SR_MBB]  = mbb;
        sr[SR_MAL]  = mal;
        sr[SR_MIF]  = mif;
        sr[SR_RXAK] = rxack;
        return sr;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string what, input logic [15:0] got,
                               input logic [15:0] exp);
        assert (got === exp)
        else abort_run($sformatf("FAILED at %0t ns: %s is %0h, expected %0h",
                                 $time, what, got, exp));
    endtask

    task automatic host_write(input logic [2:0] sel, input reg_byte_t data);
        wr_ena  = 1'b1;
        wr_addr = {sel, 2'($urandom)};    // low address bits do not decode
        wr_data = data;
        @(negedge sysclk);
        wr_ena  = 1'b0;
    endtask

    task automatic host_read(input logic [2:0] sel, output reg_byte_t data);
        rd_ena  = 1'b1;
        rd_addr = {sel, 2'($urandom)};
        @(negedge sysclk);
        rd_ena  = 1'b0;
        data    = rd_data;
    endtask

    task automatic readback_check(input logic [2:0] sel, input reg_byte_t data);
        reg_byte_t got;
        host_write(sel, data);
        host_read(sel, got);
        check_value($sformatf("readback of register %0d", sel), got, data);
    endtask

    // lat counts falling edges after the strobe, 0 skips the timing check
    task automatic wait_cmd(input byte_cmd_e exp_cmd, input int exp_lat);
        int lat;
        for (lat = 1; lat <= 60; lat++)
        begin
            @(negedge sysclk);
            if (byte_go)
                break;
        end
        assert (byte_go)
        else abort_run($sformatf("timeout waiting for the %s command", exp_cmd.name()));
        assert (byte_req.cmd == exp_cmd)
        else abort_run($sformatf("FAILED at %0t ns: command %s, expected %s",
                                 $time, byte_req.cmd.name(), exp_cmd.name()));
        if (exp_lat > 0)
            check_value($sformatf("latency of %s", exp_cmd.name()), 16'(lat), 16'(exp_lat));
    endtask

    task automatic wait_idle();
        int i;
        for (i = 0; i < 60; i++)
        begin
            @(negedge sysclk);
            if (done_cnt == go_cnt)
                break;
        end
        assert (done_cnt == go_cnt)
        else abort_run("timeout waiting for the byte controller to finish");
    endtask

    task automatic poll_sr(input reg_byte_t mask, input reg_byte_t value,
                           output reg_byte_t sr);
        int tries;
        sr = '0;
        for (tries = 0; tries < 60; tries++)
        begin
            host_read(ADDR_SR, sr);
            if ((sr & mask) == value)
                break;
        end
        assert ((sr & mask) == value)
        else abort_run($sformatf("timeout waiting for SR bits %02h to read %02h", mask, value));
    endtask

    initial
    begin
        reg_byte_t rd_val;
        reg_byte_t tx_byte;
        reg_byte_t fdr_val;
        reg_byte_t dfsrr_val;
        logic      rxack_exp;
        int        k;
        int        cycles;

        void'($urandom(32'hf012a99d));
        sysclk  = 1'b0;
        reset_n = 1'b0;
        wr_ena  = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        rd_ena  = 1'b0;
        rd_addr = '0;
        repeat (16) @(negedge sysclk);
        reset_n = 1'b1;
        @(negedge sysclk);

        check_value("byte_go_o", 16'(byte_go), 16'd0);
        check_value("byte_req_o.cmd", 16'(byte_req.cmd), 16'(CMD_IDLE));
        check_value("data_ready_o", 16'(data_ready), 16'd1);
        check_value("rd_data_o", 16'(rd_data), 16'hff);
        check_value("prescale_o", prescale, 16'd384);
        check_value("filter_rate_o", filter_rate, 16'd24);
        check_value("core_enable_o", 16'(core_enable), 16'd0);

        host_read(ADDR_ADR, rd_val);
        check_value("ADR after reset", 16'(rd_val), 16'h00);
        host_read(ADDR_FDR, rd_val);
        check_value("FDR after reset", 16'(rd_val), 16'h00);
        host_read(ADDR_CR, rd_val);
        check_value("CR after reset", 16'(rd_val), 16'h00);
        host_read(ADDR_SR, rd_val);
        check_value("SR after reset", 16'(rd_val), 16'(sr_ref(1, 0, 0, 0, 1)));
        host_read(ADDR_DFSRR, rd_val);
        check_value("DFSRR after reset", 16'(rd_val), 16'h10);
        host_read(3'd6, rd_val);
        check_value("unused slot 6", 16'(rd_val), 16'h81);
        host_read(3'd7, rd_val);
        check_value("unused slot 7", 16'(rd_val), 16'h81);
        host_write(ADDR_SR, 8'h00);    // no effect while the bus is idle
        host_read(ADDR_SR, rd_val);
        check_value("SR after idle write", 16'(rd_val), 16'h81);

        readback_check(ADDR_ADR, 8'($urandom));
        readback_check(ADDR_FDR, 8'($urandom));
        readback_check(ADDR_DFSRR, 8'($urandom));
        readback_check(ADDR_CR, 8'($urandom) & ~8'(1 << CR_MSTA));

        for (k = 0; k < 6; k++)
        begin
            fdr_val = {2'(k), FDR_CODES[k]};    // walks all four upper bit patterns
            host_write(ADDR_FDR, fdr_val);
            @(negedge sysclk);
            check_value($sformatf("prescale_o for FDR %02h", fdr_val), prescale,
                        prescale_ref(fdr_val));
        end

        for (k = 0; k < 4; k++)
        begin
            fdr_val   = {2'($urandom), FDR_CODES[$urandom_range(5, 0)]};
            dfsrr_val = {2'($urandom), 6'($urandom_range(63, 1))};
            host_write(ADDR_FDR, fdr_val);
            host_write(ADDR_DFSRR, dfsrr_val);
            for (cycles = 0; cycles < 70; cycles++)
            begin
                @(negedge sysclk);
                if (filter_rate == filter_ref(prescale_ref(fdr_val), dfsrr_val))
                    break;
            end
            check_value($sformatf("filter_rate_o for FDR %02h DFSRR %02h", fdr_val, dfsrr_val),
                        filter_rate, filter_ref(prescale_ref(fdr_val), dfsrr_val));
        end

        // write transfer
        rxack_exp = 1'b1;
        host_write(ADDR_CR, 8'h00);
        host_write(ADDR_CR, 8'hb0);    // MEN MSTA MTX
        wait_cmd(CMD_START, 2);
        check_value("core_enable_o", 16'(core_enable), 16'd1);
        poll_sr(8'(1 << SR_MBB), 8'(1 << SR_MBB), rd_val);
        check_value("SR after start", 16'(rd_val), 16'(sr_ref(1, 1, 0, 0, rxack_exp)));
        tx_byte = 8'($urandom);
        host_write(ADDR_DR, tx_byte);
        wait_cmd(CMD_WRITE, 2);
        check_value("tx_data of WRITE", 16'(byte_req.tx_data), 16'(tx_byte));
        wait_cmd(CMD_RD_ACK, 0);
        poll_sr(8'(1 << SR_MCF), 8'(1 << SR_MCF), rd_val);
        rxack_exp = last_rxack;
        check_value("SR after write", 16'(rd_val), 16'(sr_ref(1, 1, 0, 1, rxack_exp)));

        // repeated start, then one more byte
        host_write(ADDR_CR, 8'hb4);
        wait_cmd(CMD_RESTART, 3);
        host_write(ADDR_CR, 8'hb0);
        wait_idle();
        host_write(ADDR_SR, 8'h00);    // clear MIF
        tx_byte = 8'($urandom);
        host_write(ADDR_DR, tx_byte);
        wait_cmd(CMD_WRITE, 2);
        check_value("tx_data after restart", 16'(byte_req.tx_data), 16'(tx_byte));
        wait_cmd(CMD_RD_ACK, 0);
        poll_sr(8'(1 << SR_MCF), 8'(1 << SR_MCF), rd_val);
        rxack_exp = last_rxack;
        check_value("SR after second write", 16'(rd_val), 16'(sr_ref(1, 1, 0, 1, rxack_exp)));

        // read with master ack
        host_write(ADDR_SR, 8'h00);
        host_read(ADDR_DR, rd_val);
        wait_cmd(CMD_READ, 2);
        wait_cmd(CMD_WR_ACK, 0);
        check_value("rd_data_o after read", 16'(rd_data), 16'(last_rx));
        poll_sr(8'(1 << SR_MCF), 8'(1 << SR_MCF), rd_val);
        rxack_exp = last_rxack;
        check_value("SR after acked read", 16'(rd_val), 16'(sr_ref(1, 1, 0, 1, rxack_exp)));

        // read with TXAK, no ack phase follows
        host_write(ADDR_SR, 8'h00);
        host_write(ADDR_CR, 8'hb8);
        host_read(ADDR_DR, rd_val);
        wait_cmd(CMD_READ, 2);
        for (cycles = 0; cycles < 60; cycles++)
        begin
            @(negedge sysclk);
            assert (!byte_go)
            else abort_run("a byte command was issued after a read with TXAK set");
            if (data_ready)
                break;
        end
        assert (data_ready)
        else abort_run("timeout waiting for data_ready_o after a read with TXAK set");
        check_value("rd_data_o after TXAK read", 16'(rd_data), 16'(last_rx));
        for (cycles = 0; cycles < 20; cycles++)
        begin
            @(negedge sysclk);
            assert (!byte_go)
            else abort_run("a byte command was issued after a read with TXAK set");
        end
        host_read(ADDR_SR, rd_val);
        check_value("SR after TXAK read", 16'(rd_val), 16'(sr_ref(1, 1, 0, 0, rxack_exp)));

        // stop
        host_write(ADDR_CR, 8'h80);
        wait_cmd(CMD_STOP, 2);
        poll_sr(8'(1 << SR_MBB), 8'h00, rd_val);
        check_value("SR after stop", 16'(rd_val), 16'(sr_ref(1, 0, 0, 0, rxack_exp)));
        check_value("byte_req_o.cmd after stop", 16'(byte_req.cmd), 16'(CMD_IDLE));
        check_value("data_ready_o after stop", 16'(data_ready), 16'd1);

        repeat (4) @(negedge sysclk);
        if (dut_i.u_sva.fail_cnt == 0)
        begin
            $display("SIMULATION PASSED");
            $finish;
        end
        else
        begin
            abort_run("protocol assertions on byte_go_o failed");
        end
    end

    initial
    begin
        repeat (20000) @(posedge sysclk);
        abort_run("simulation did not finish within 20000 clock cycles");
    end

endmodule

`default_nettype wire

/* verilog.f */
i2c_master_pkg.sv
i2c_restoring_divider.sv
i2c_clock_config.sv
i2c_reg_file.sv
i2c_cmd_sequencer.sv
i2c_master_ctrl.sv
i2c_master_ctrl_sva.sv
tb_i2c_master_ctrl.sv
